// ==== include/membridge_defs.svh ====
`ifndef MEMBRIDGE_DEFS_SVH
`define MEMBRIDGE_DEFS_SVH

// word quantities count 64-bit words
`define MB_WORD_AW          29     // word address or word count
`define MB_BYTE_AW          32     // axi byte address

// burst shaping
`define MB_BURST_WORDS      16     // beats in a full burst
`define MB_MAX_OUTSTANDING  8      // bursts issued w/o response
`define MB_CNT_W            8      // status counter width

// apb register map, byte offsets
`define MB_REG_CTRL         8'h00  // enable, start, reload
`define MB_REG_LO           8'h04  // window base
`define MB_REG_SIZE         8'h08  // window size
`define MB_REG_START        8'h0C  // start offset in window
`define MB_REG_LEN          8'h10  // transfer length
`define MB_REG_STATUS       8'h14  // read only

`endif

// ==== design/membridge_pkg.sv ====
`include "membridge_defs.svh"

package membridge_pkg;

    typedef logic [`MB_WORD_AW-1:0]              word_addr_t; // word address or count
    typedef logic [`MB_BYTE_AW-1:0]              byte_addr_t; // axi address
    typedef logic [63:0]                         data_t;      // one source word
    typedef logic [$clog2(`MB_BURST_WORDS)-1:0]  beat_cnt_t;  // awlen field
    typedef logic [`MB_CNT_W-1:0]                burst_cnt_t; // status counters

    // address generator states
    typedef enum logic [1:0] {
        IDLE,   // waiting for start
        CALC,   // form address and length
        ISSUE   // aw valid until accepted
    } ag_state_t;

    typedef enum logic [7:0] {
        REG_CTRL   = `MB_REG_CTRL,
        REG_LO     = `MB_REG_LO,
        REG_SIZE   = `MB_REG_SIZE,
        REG_START  = `MB_REG_START,
        REG_LEN    = `MB_REG_LEN,
        REG_STATUS = `MB_REG_STATUS
    } reg_offs_t;

endpackage

// ==== design/membridge_regs.sv ====
`timescale 1ns/1ps
`include "membridge_defs.svh"

module membridge_regs (
    input  logic                      hclk,
    input  logic                      rst,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [7:0]                paddr_i,
    input  logic [31:0]               pwdata_i,
    input  logic                      busy_i,
    input  logic                      done_i,
    input  logic                      err_i,
    input  membridge_pkg::burst_cnt_t bursts_i,
    input  membridge_pkg::burst_cnt_t resp_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    output logic                      enable_o,
    output logic                      start_o,
    output logic                      reset_addr_o,
    output membridge_pkg::word_addr_t lo_addr_o,
    output membridge_pkg::word_addr_t size_o,
    output membridge_pkg::word_addr_t start_addr_o,
    output membridge_pkg::word_addr_t len_o
);
    import membridge_pkg::*;

    localparam int ALIGN = $clog2(`MB_BURST_WORDS); // burst alignment bits

    logic       access;      // apb access phase
    logic       wr;          // write in access phase
    logic       wr_ctrl;
    logic       mapped;      // offset hits a register
    word_addr_t wdata_word;  // write data cut to word width
    word_addr_t wdata_align; // same, low bits dropped

    assign pready_o    = 1'b1; // no wait states
    assign access      = psel_i & penable_i;
    assign wr          = access & pwrite_i;
    assign wr_ctrl     = wr & (paddr_i == REG_CTRL);
    assign wdata_word  = pwdata_i[`MB_WORD_AW-1:0];
    assign wdata_align = {wdata_word[`MB_WORD_AW-1:ALIGN], {ALIGN{1'b0}}};
    assign pslverr_o   = access & (~mapped | (pwrite_i & (paddr_i == REG_STATUS)));

    // readback mux
    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            REG_CTRL:   prdata_o = {31'd0, enable_o};
            REG_LO:     prdata_o = 32'(lo_addr_o);
            REG_SIZE:   prdata_o = 32'(size_o);
            REG_START:  prdata_o = 32'(start_addr_o);
            REG_LEN:    prdata_o = 32'(len_o);
            REG_STATUS: prdata_o = {8'd0, resp_i, bursts_i, 5'd0, err_i, busy_i, done_i};
            default:    mapped = 1'b0; // unmapped offset
        endcase
    end

    // window and length
    always_ff @(posedge hclk) begin
        if (wr && (paddr_i == REG_LO)) begin
            lo_addr_o <= wdata_align; // 16-word aligned
        end
        if (wr && (paddr_i == REG_SIZE)) begin
            size_o <= wdata_align;
        end
        if (wr && (paddr_i == REG_START)) begin
            start_addr_o <= wdata_align;
        end
        if (wr && (paddr_i == REG_LEN)) begin
            len_o <= wdata_word; // any length
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            enable_o     <= 1'b0;
            start_o      <= 1'b0;
            reset_addr_o <= 1'b0;
        end else begin
            // one cycle pulse, dropped while a transfer runs
            start_o <= wr_ctrl & pwdata_i[1] & ~busy_i & ~start_o;
            if (wr_ctrl) begin
                enable_o     <= pwdata_i[0];
                reset_addr_o <= pwdata_i[2]; // reload offset from START
            end
        end
    end

endmodule

// ==== design/membridge_addr_gen.sv ====
`timescale 1ns/1ps
`include "membridge_defs.svh"

module membridge_addr_gen (
    input  logic                      hclk,
    input  logic                      rst,
    input  logic                      start_i,
    input  logic                      reset_addr_i,
    input  membridge_pkg::word_addr_t lo_addr_i,
    input  membridge_pkg::word_addr_t size_i,
    input  membridge_pkg::word_addr_t start_addr_i,
    input  membridge_pkg::word_addr_t len_i,
    input  logic                      allow_i,
    input  logic                      afi_awready_i,
    output membridge_pkg::byte_addr_t afi_awaddr_o,
    output membridge_pkg::beat_cnt_t  afi_awlen_o,
    output logic                      afi_awvalid_o,
    output logic                      aw_fire_o
);
    import membridge_pkg::*;

    localparam int         BW    = $clog2(`MB_BURST_WORDS); // bits inside a burst
    localparam word_addr_t BURST = word_addr_t'(`MB_BURST_WORDS);

    ag_state_t               state;
    word_addr_t              rel_addr; // offset from window base
    word_addr_t              left;     // words not yet covered by an aw
    logic                    partial;  // less than a full burst left
    logic                    last_win; // current burst is the top of the window
    logic [`MB_WORD_AW-1:BW] last_blk; // burst index before rollover
    word_addr_t              tail;     // size of a partial burst

    assign partial  = ~|left[`MB_WORD_AW-1:BW];
    assign last_blk = size_i[`MB_WORD_AW-1:BW] - 1'b1;
    assign tail     = {{(`MB_WORD_AW-BW){1'b0}}, left[BW-1:0]};

    // allow can only rise while valid is up, so payload holds
    assign afi_awvalid_o = (state == ISSUE) & allow_i;
    assign aw_fire_o     = afi_awvalid_o & afi_awready_i;

    // burst payload, formed in CALC and held through ISSUE
    always_ff @(posedge hclk) begin
        if (state == CALC) begin
            afi_awaddr_o <= {lo_addr_i + rel_addr, 3'b000}; // words to bytes
            afi_awlen_o  <= partial ? left[BW-1:0] - 1'b1 : '1;
            last_win     <= rel_addr[`MB_WORD_AW-1:BW] == last_blk;
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            rel_addr <= '0;
            left     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        left  <= len_i;
                        state <= CALC;
                        if (reset_addr_i) begin
                            rel_addr <= start_addr_i; // else continue
                        end
                    end
                end
                CALC: begin
                    state <= (left == '0) ? IDLE : ISSUE; // nothing left, stop
                end
                ISSUE: begin
                    if (aw_fire_o) begin
                        state <= CALC;
                        left  <= partial ? '0 : left - BURST;
                        if (partial) begin
                            rel_addr <= rel_addr + tail; // final short burst
                        end else if (last_win) begin
                            rel_addr <= '0; // back to window base
                        end else begin
                            rel_addr <= rel_addr + BURST;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/membridge_data_burst.sv ====
`timescale 1ns/1ps
`include "membridge_defs.svh"

module membridge_data_burst (
    input  logic                      hclk,
    input  logic                      rst,
    input  logic                      start_i,
    input  membridge_pkg::word_addr_t len_i,
    input  logic                      src_valid_i,
    input  membridge_pkg::data_t      src_data_i,
    input  logic                      afi_wready_i,
    output logic                      src_ready_o,
    output membridge_pkg::data_t      afi_wdata_o,
    output logic                      afi_wvalid_o,
    output logic                      afi_wlast_o,
    output logic                      data_done_o
);
    import membridge_pkg::*;

    localparam beat_cnt_t LAST_POS = beat_cnt_t'(`MB_BURST_WORDS - 1); // 16th beat

    logic       active;     // streaming words
    word_addr_t left;       // words still to send
    beat_cnt_t  beat_pos;   // position inside current burst
    logic       beat;       // word moves this cycle
    logic       final_beat; // last word of the transfer

    // source feeds the w channel straight through
    assign src_ready_o  = active & afi_wready_i;
    assign afi_wvalid_o = active & src_valid_i;
    assign afi_wdata_o  = src_data_i;
    assign beat         = afi_wvalid_o & afi_wready_i;
    assign final_beat   = left == word_addr_t'(1);

    // stable while valid waits, counters move only on a beat
    assign afi_wlast_o = active & (final_beat | (beat_pos == LAST_POS));

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            active      <= 1'b0;
            left        <= '0;
            beat_pos    <= '0;
            data_done_o <= 1'b0;
        end else if (start_i) begin
            active      <= len_i != '0;
            left        <= len_i;
            beat_pos    <= '0;
            data_done_o <= len_i == '0; // empty transfer done at once
        end else if (beat) begin
            left     <= left - 1'b1;
            beat_pos <= afi_wlast_o ? '0 : beat_pos + 1'b1; // restart per burst
            if (final_beat) begin
                active      <= 1'b0;
                data_done_o <= 1'b1; // held until next start
            end
        end
    end

endmodule

// ==== design/membridge_xfer_ctrl.sv ====
`timescale 1ns/1ps
`include "membridge_defs.svh"

module membridge_xfer_ctrl (
    input  logic                      hclk,
    input  logic                      rst,
    input  logic                      start_i,
    input  logic                      enable_i,
    input  logic                      aw_fire_i,
    input  logic                      data_done_i,
    input  logic                      afi_bvalid_i,
    input  logic [1:0]                afi_bresp_i,
    output logic                      afi_bready_o,
    output logic                      allow_o,
    output logic                      busy_o,
    output logic                      done_o,
    output logic                      err_o,
    output membridge_pkg::burst_cnt_t bursts_o,
    output membridge_pkg::burst_cnt_t resp_o
);
    import membridge_pkg::*;

    localparam burst_cnt_t MAX_OUT = burst_cnt_t'(`MB_MAX_OUTSTANDING);

    burst_cnt_t in_flight; // issued without response yet
    logic       b_fire;
    logic       bad_resp;  // anything but OKAY
    logic       finish;    // all data sent and acknowledged

    assign afi_bready_o = 1'b1; // responses always taken
    assign b_fire       = afi_bvalid_i & afi_bready_o;
    assign bad_resp     = b_fire & (afi_bresp_i != 2'b00);
    assign in_flight    = bursts_o - resp_o; // wraps cleanly
    assign allow_o      = in_flight < MAX_OUT; // room below the limit
    assign finish       = busy_o & data_done_i & (in_flight == '0);

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            bursts_o <= '0;
            resp_o   <= '0;
            err_o    <= 1'b0;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            if (start_i) begin
                bursts_o <= '0;
            end else if (aw_fire_i) begin
                bursts_o <= bursts_o + 1'b1;
            end
            if (start_i) begin
                resp_o <= '0;
            end else if (b_fire) begin
                resp_o <= resp_o + 1'b1;
            end
            if (start_i) begin
                err_o <= 1'b0;
            end else if (bad_resp) begin
                err_o <= 1'b1; // sticky until next start
            end
            if (start_i) begin
                busy_o <= 1'b1;
            end else if (finish) begin
                busy_o <= 1'b0; // same edge as done
            end
            if (start_i) begin
                done_o <= 1'b0;
            end else if (finish) begin
                done_o <= 1'b1;
            end else if (!enable_i && !busy_o) begin
                done_o <= 1'b0; // disable when idle clears done
            end
        end
    end

endmodule

// ==== design/membridge_top.sv ====
`timescale 1ns/1ps

module membridge_top (
    input  logic                      hclk,
    input  logic                      rst,
    // apb slave
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [7:0]                paddr_i,
    input  logic [31:0]               pwdata_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    // source stream
    input  logic                      src_valid_i,
    input  membridge_pkg::data_t      src_data_i,
    output logic                      src_ready_o,
    // axi write port
    output membridge_pkg::byte_addr_t afi_awaddr_o,
    output membridge_pkg::beat_cnt_t  afi_awlen_o,
    output logic                      afi_awvalid_o,
    input  logic                      afi_awready_i,
    output membridge_pkg::data_t      afi_wdata_o,
    output logic                      afi_wlast_o,
    output logic                      afi_wvalid_o,
    input  logic                      afi_wready_i,
    input  logic                      afi_bvalid_i,
    input  logic [1:0]                afi_bresp_i,
    output logic                      afi_bready_o
);
    import membridge_pkg::*;

    logic       enable;     // ctrl bit 0
    logic       start;      // start pulse
    logic       reset_addr; // reload offset on start
    word_addr_t lo_addr;
    word_addr_t size;
    word_addr_t start_addr;
    word_addr_t len;
    logic       busy;
    logic       done;
    logic       err;
    burst_cnt_t bursts;     // aw handshakes
    burst_cnt_t resp;       // b handshakes
    logic       allow;      // room for another burst
    logic       aw_fire;
    logic       data_done;

    membridge_regs regs_i (
        .hclk (hclk), .rst (rst),
        .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
        .paddr_i (paddr_i), .pwdata_i (pwdata_i),
        .busy_i (busy), .done_i (done), .err_i (err), .bursts_i (bursts), .resp_i (resp),
        .prdata_o (prdata_o), .pready_o (pready_o), .pslverr_o (pslverr_o),
        .enable_o (enable), .start_o (start), .reset_addr_o (reset_addr),
        .lo_addr_o (lo_addr), .size_o (size), .start_addr_o (start_addr), .len_o (len)
    );

    // aw side, runs alongside the w side
    membridge_addr_gen addr_gen_i (
        .hclk (hclk), .rst (rst),
        .start_i (start), .reset_addr_i (reset_addr),
        .lo_addr_i (lo_addr), .size_i (size), .start_addr_i (start_addr), .len_i (len),
        .allow_i (allow), .afi_awready_i (afi_awready_i),
        .afi_awaddr_o (afi_awaddr_o), .afi_awlen_o (afi_awlen_o),
        .afi_awvalid_o (afi_awvalid_o), .aw_fire_o (aw_fire)
    );

    membridge_data_burst data_burst_i (
        .hclk (hclk), .rst (rst),
        .start_i (start), .len_i (len),
        .src_valid_i (src_valid_i), .src_data_i (src_data_i), .afi_wready_i (afi_wready_i),
        .src_ready_o (src_ready_o), .afi_wdata_o (afi_wdata_o),
        .afi_wvalid_o (afi_wvalid_o), .afi_wlast_o (afi_wlast_o), .data_done_o (data_done)
    );

    // joins both sides with the b channel
    membridge_xfer_ctrl xfer_ctrl_i (
        .hclk (hclk), .rst (rst),
        .start_i (start), .enable_i (enable), .aw_fire_i (aw_fire), .data_done_i (data_done),
        .afi_bvalid_i (afi_bvalid_i), .afi_bresp_i (afi_bresp_i),
        .afi_bready_o (afi_bready_o), .allow_o (allow),
        .busy_o (busy), .done_o (done), .err_o (err), .bursts_o (bursts), .resp_o (resp)
    );

endmodule

// ==== verification/membridge_tb.sv ====
`timescale 1ns/1ps
`include "membridge_defs.svh"

module membridge_tb;
    import membridge_pkg::*;

    localparam int TOTAL_WORDS = 5 + 40 + 48 + 20 + 200 + 32 + 5;
    localparam int CYCLE_LIMIT = TOTAL_WORDS * 12 + 2000; // worst stall per word, plus apb polls

    logic       hclk, rst, psel, penable, pwrite, pready, pslverr;
    logic [7:0] paddr;
    logic [31:0] pwdata, prdata;
    logic       src_valid, src_ready, awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    data_t      src_data, wdata;
    byte_addr_t awaddr;
    beat_cnt_t  awlen;
    logic [1:0] bresp;

    byte_addr_t aw_addr_q[$]; // slave side records
    beat_cnt_t  aw_len_q[$];
    data_t      w_data_q[$];
    logic       w_last_q[$];
    int         aw_cnt, wlast_cnt, b_cnt, b_delay, inject_at;
    int         errors, tests, failed, cycles;
    logic       rnd_mode;      // random stalls on
    logic [31:0] lfsr;
    word_addr_t exp_rel;       // expected offset in window

    membridge_top dut_i (
        .hclk (hclk), .rst (rst),
        .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
        .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
        .src_valid_i (src_valid), .src_data_i (src_data), .src_ready_o (src_ready),
        .afi_awaddr_o (awaddr), .afi_awlen_o (awlen), .afi_awvalid_o (awvalid),
        .afi_awready_i (awready), .afi_wdata_o (wdata), .afi_wlast_o (wlast),
        .afi_wvalid_o (wvalid), .afi_wready_i (wready), .afi_bvalid_i (bvalid),
        .afi_bresp_i (bresp), .afi_bready_o (bready)
    );

    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;
    end

    // galois lfsr stepped once per bit
    function automatic logic next_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) lfsr = lfsr ^ 32'h8020_0003;
        return lsb;
    endfunction

    // axi slave model and source
    always @(posedge hclk) begin
        if (!rst) begin
            if (awvalid && awready) begin
                aw_addr_q.push_back(awaddr);
                aw_len_q.push_back(awlen);
                aw_cnt++;
            end
            if (wvalid && wready) begin
                w_data_q.push_back(wdata);
                w_last_q.push_back(wlast);
                if (wlast) wlast_cnt++;
            end
            if (bvalid) begin
                check_val("afi_bready", bready, 1);
                bvalid <= 1'b0; // bready is tied high
                b_cnt++;
                b_delay = rnd_mode ? {next_bit(), next_bit(), next_bit()} : 0;
            end else if (((aw_cnt < wlast_cnt) ? aw_cnt : wlast_cnt) > b_cnt) begin
                if (b_delay == 0) begin
                    bvalid <= 1'b1;
                    bresp  <= (b_cnt == inject_at) ? 2'b10 : 2'b00; // slverr when injected
                end else begin
                    b_delay--;
                end
            end
            assert (aw_cnt - b_cnt <= `MB_MAX_OUTSTANDING) else begin
                $display("more than %0d bursts outstanding at %0t", `MB_MAX_OUTSTANDING, $time);
                errors++;
            end
            if (src_valid && src_ready) src_data <= src_data + 1; // counter data
            awready   <= rnd_mode ? next_bit() : 1'b1;
            wready    <= rnd_mode ? next_bit() : 1'b1;
            src_valid <= rnd_mode ? next_bit() : 1'b1;
        end
    end

    always @(posedge hclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run passed %0d cycles without finishing", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        @(posedge hclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge hclk);
        penable <= 1'b1;
        @(posedge hclk);
        rdata = prdata; // access phase still on the bus
        err   = pslverr;
        check_val("pready", pready, 1);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors != err0) begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - err0);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic reg_test();
        logic [31:0] rd;
        logic        e;
        int          err0;
        err0 = errors;
        check_val("afi_awvalid", awvalid, 0); // idle after reset
        check_val("afi_wvalid", wvalid, 0);
        check_val("src_ready", src_ready, 0);
        apb_access(1, `MB_REG_LO, 32'h0000_0123, rd, e);
        apb_access(1, `MB_REG_SIZE, 32'h0000_0047, rd, e);
        apb_access(1, `MB_REG_START, 32'h0000_001f, rd, e);
        apb_access(1, `MB_REG_LEN, 32'h0000_0025, rd, e);
        apb_access(0, `MB_REG_LO, 0, rd, e);
        check_val("LO", rd, 32'h120);
        apb_access(0, `MB_REG_SIZE, 0, rd, e);
        check_val("SIZE", rd, 32'h40);
        apb_access(0, `MB_REG_START, 0, rd, e);
        check_val("START", rd, 32'h10);
        apb_access(0, `MB_REG_LEN, 0, rd, e);
        check_val("LEN", rd, 32'h25);
        apb_access(1, `MB_REG_STATUS, 32'h1, rd, e);
        check_val("pslverr on STATUS write", e, 1);
        apb_access(0, 8'h18, 0, rd, e);
        check_val("pslverr on unmapped read", e, 1);
        end_test("register access", err0);
    endtask

    // program, start, wait for done and compare with the burst rules
    task automatic run_xfer(input word_addr_t lo, input word_addr_t size, input word_addr_t start,
                            input word_addr_t len, input logic reload, output logic [31:0] st);
        byte_addr_t exp_addr[$];
        beat_cnt_t  exp_len[$];
        word_addr_t left, n;
        data_t      d0;
        logic       e;
        aw_addr_q.delete();
        aw_len_q.delete();
        w_data_q.delete();
        w_last_q.delete();
        apb_access(1, `MB_REG_LO, 32'(lo), st, e);
        apb_access(1, `MB_REG_SIZE, 32'(size), st, e);
        apb_access(1, `MB_REG_START, 32'(start), st, e);
        apb_access(1, `MB_REG_LEN, 32'(len), st, e);
        if (reload) exp_rel = start;
        left = len;
        while (left != 0) begin
            n = (left < 16) ? left : 16;
            exp_addr.push_back({lo + exp_rel, 3'b000});
            exp_len.push_back(beat_cnt_t'(n - 1));
            if (n < 16) exp_rel = exp_rel + n;          // tail burst
            else if (exp_rel + 16 >= size) exp_rel = 0; // top of window
            else exp_rel = exp_rel + 16;
            left = left - n;
        end
        d0 = src_data;
        apb_access(1, `MB_REG_CTRL, reload ? 32'h7 : 32'h3, st, e);
        do apb_access(0, `MB_REG_STATUS, 0, st, e); while (!st[0]);
        check_val("busy", st[1], 0);
        check_val("bursts", st[15:8], exp_addr.size());
        check_val("responses", st[23:16], exp_addr.size());
        check_val("aw count", aw_addr_q.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size() && i < aw_addr_q.size(); i++) begin
            check_val($sformatf("afi_awaddr[%0d]", i), aw_addr_q[i], exp_addr[i]);
            check_val($sformatf("afi_awlen[%0d]", i), aw_len_q[i], exp_len[i]);
        end
        check_val("beat count", w_data_q.size(), len);
        for (int i = 0; i < w_data_q.size(); i++) begin
            check_val($sformatf("afi_wdata[%0d]", i), w_data_q[i], d0 + i);
            check_val($sformatf("afi_wlast[%0d]", i), w_last_q[i],
                      ((i + 1) % 16 == 0) || (i == len - 1));
        end
    endtask

    task automatic xfer_test(input string name, input word_addr_t lo, input word_addr_t size,
                             input word_addr_t start, input word_addr_t len);
        logic [31:0] st;
        int          err0;
        err0 = errors;
        run_xfer(lo, size, start, len, 1'b1, st);
        end_test(name, err0);
    endtask

    task automatic rollover_test();
        logic [31:0] st;
        int          err0;
        err0 = errors;
        run_xfer(29'h200, 29'd32, 29'd16, 29'd48, 1'b1, st); // offsets 16, 0, 16
        run_xfer(29'h200, 29'd32, 29'd16, 29'd20, 1'b0, st); // continues without reload
        end_test("rollover", err0);
    endtask

    task automatic error_test();
        logic [31:0] st;
        int          err0;
        err0 = errors;
        inject_at = b_cnt + 1; // second burst answers slverr
        run_xfer(29'h400, 29'h1000, 29'h0, 29'd32, 1'b1, st);
        check_val("status err", st[2], 1);
        inject_at = -1;
        run_xfer(29'h400, 29'h1000, 29'h0, 29'd5, 1'b1, st);
        check_val("status err after start", st[2], 0);
        end_test("error response", err0);
    endtask

    initial begin
        rst       = 1'b1;
        psel      = 0;
        penable   = 0;
        pwrite    = 0;
        paddr     = 0;
        pwdata    = 0;
        src_valid = 0;
        src_data  = 0;
        awready   = 0;
        wready    = 0;
        bvalid    = 0;
        bresp     = 0;
        aw_cnt    = 0;
        wlast_cnt = 0;
        b_cnt     = 0;
        b_delay   = 0;
        inject_at = -1;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        cycles    = 0;
        rnd_mode  = 0;
        lfsr      = 32'h4f11_368f;
        exp_rel   = 0;
        repeat (2) @(posedge hclk);
        rst <= 1'b0;
        reg_test();
        xfer_test("short transfer", 29'h100, 29'h1000, 29'h20, 29'd5);
        xfer_test("multi burst", 29'h100, 29'h1000, 29'h40, 29'd40);
        rollover_test();
        rnd_mode = 1'b1;
        xfer_test("back-pressure", 29'h300, 29'h1000, 29'h0, 29'd200); // enough bursts to hit the limit
        rnd_mode = 1'b0;
        error_test();
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== membridge.f ====
+incdir+include
design/membridge_pkg.sv
design/membridge_regs.sv
design/membridge_addr_gen.sv
design/membridge_data_burst.sv
design/membridge_xfer_ctrl.sv
design/membridge_top.sv
verification/membridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the membridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f membridge.f \
    --top-module membridge_tb -o membridge_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/membridge_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
